// File: src/xbar_defs.svh
`ifndef XBAR_DEFS_SVH
`define XBAR_DEFS_SVH

// EBI bus widths
`define XBAR_DATA_W 16
`define XBAR_ADDR_W 21

// Switch image, sixteen words of 16 bits
`define XBAR_WORDS 16
`define XBAR_IMAGE_W 256

// ebi_clk cycles per serial bit, must be even
// First half of a period has xbar_clock low, second half high
`define XBAR_SCLK_DIV 4

// Bit counter, wide enough to hold the image width
`define XBAR_CNT_W 9

`endif

// File: src/xbar_pkg.sv
`include "xbar_defs.svh"

package xbar_pkg;

  // Command register opcodes, one full EBI data word
  typedef enum logic [`XBAR_DATA_W-1:0] {
    CMD_NOP  = `XBAR_DATA_W'd0,
    CMD_LOAD = `XBAR_DATA_W'd1
  } xbar_cmd_e;

  // Serial engine states
  // ST_SHIFT covers the 256 data periods
  // ST_LATCH is the single pclk low period
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_SHIFT = 2'd1,
    ST_LATCH = 2'd2
  } xbar_state_e;

endpackage

// File: src/xbar_regs.sv
`timescale 1ns/1ps
`include "xbar_defs.svh"

module xbar_regs #(
  parameter int POSITION = 0
) (
  input  logic                     ebi_clk,
  input  logic                     reset,
  input  logic                     re,
  input  logic                     wr,
  input  logic [`XBAR_DATA_W-1:0]  data,
  input  logic [`XBAR_ADDR_W-1:0]  addr,
  input  logic                     busy,
  output logic [`XBAR_IMAGE_W-1:0] image,
  output logic                     load_start,
  output logic [`XBAR_DATA_W-1:0]  rdata,
  output logic                     rvalid
);

  localparam int IDX_W = $clog2(`XBAR_WORDS);

  logic                    cs;
  logic                    is_cmd;
  logic [IDX_W-1:0]        word_idx;
  logic                    wr_word;
  logic                    wr_cmd;
  logic                    rd_hit;
  xbar_pkg::xbar_cmd_e     cmd;
  logic [`XBAR_DATA_W-1:0] status;
  logic [`XBAR_DATA_W-1:0] words [`XBAR_WORDS];

  // Chip select compare, taken at the clock edge together with the strobes
  assign cs = (addr[7:0] == 8'(POSITION));

  // addr[13] picks the command/status register, addr[11:8] the image word
  assign is_cmd   = addr[13];
  assign word_idx = addr[8 +: IDX_W];

  assign wr_word = cs && wr && !is_cmd;
  assign wr_cmd  = cs && wr && is_cmd;
  assign rd_hit  = cs && re;

  assign cmd = xbar_pkg::xbar_cmd_e'(data);

  // Status word, only bit 0 is defined
  assign status = {{(`XBAR_DATA_W-1){1'b0}}, busy};

  // Image storage
  // Writes while busy are fine, the engine has its own copy
  always_ff @(posedge ebi_clk) begin
    if (wr_word) begin
      words[word_idx] <= data;
    end
  end

  // Word 15 lands in the top bits, so image[255] is word 15 bit 15
  always_comb begin
    for (int i = 0; i < `XBAR_WORDS; i++) begin
      image[i*`XBAR_DATA_W +: `XBAR_DATA_W] = words[i];
    end
  end

  // Command decode
  // A LOAD seen while busy is dropped here and never retried
  always_ff @(posedge ebi_clk) begin
    if (reset) begin
      load_start <= 1'b0;
    end else begin
      load_start <= 1'b0;
      if (wr_cmd) begin
        case (cmd)
          xbar_pkg::CMD_LOAD: load_start <= !busy;
          xbar_pkg::CMD_NOP:  load_start <= 1'b0;
          default:            load_start <= 1'b0;
        endcase
      end
    end
  end

  // Readback valid, one cycle after re
  always_ff @(posedge ebi_clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd_hit;
    end
  end

  // Readback data, held until the next read
  always_ff @(posedge ebi_clk) begin
    if (rd_hit) begin
      if (is_cmd) begin
        rdata <= status;
      end else begin
        rdata <= words[word_idx];
      end
    end
  end

endmodule

// File: src/xbar_shifter.sv
`timescale 1ns/1ps
`include "xbar_defs.svh"

module xbar_shifter (
  input  logic                     ebi_clk,
  input  logic                     reset,
  input  logic [`XBAR_IMAGE_W-1:0] image,
  input  logic                     load_start,
  output logic                     busy,
  output logic                     xbar_clock,
  output logic                     pclk,
  output logic                     sin
);

  localparam int DIV_W = $clog2(`XBAR_SCLK_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`XBAR_SCLK_DIV - 1);
  localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(`XBAR_SCLK_DIV / 2);
  localparam logic [`XBAR_CNT_W-1:0] BIT_LAST = `XBAR_CNT_W'(`XBAR_IMAGE_W - 1);

  xbar_pkg::xbar_state_e    state;
  logic [DIV_W-1:0]         div_cnt;
  logic [`XBAR_CNT_W-1:0]   bit_cnt;
  logic [`XBAR_IMAGE_W-1:0] shreg;
  logic                     period_end;
  logic                     last_bit;

  assign period_end = (div_cnt == DIV_LAST);
  assign last_bit   = (bit_cnt == BIT_LAST);

  // State machine with divider and bit counter
  always_ff @(posedge ebi_clk) begin
    if (reset) begin
      state   <= xbar_pkg::ST_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        xbar_pkg::ST_IDLE: begin
          div_cnt <= '0;
          bit_cnt <= '0;
          if (load_start) begin
            state <= xbar_pkg::ST_SHIFT;
          end
        end

        xbar_pkg::ST_SHIFT: begin
          if (period_end) begin
            div_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            // After the 256th period comes the latch pulse
            if (last_bit) begin
              state <= xbar_pkg::ST_LATCH;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        xbar_pkg::ST_LATCH: begin
          if (period_end) begin
            div_cnt <= '0;
            state   <= xbar_pkg::ST_IDLE;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        default: begin
          state <= xbar_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Shift register loaded on start and moved left at the end of each period
  // so sin changes only at the start of a period
  always_ff @(posedge ebi_clk) begin
    if (load_start) begin
      shreg <= image;
    end else if (state == xbar_pkg::ST_SHIFT && period_end) begin
      shreg <= {shreg[`XBAR_IMAGE_W-2:0], 1'b0};
    end
  end

  // Busy from the cycle after load_start to the end of the latch period
  assign busy = (state != xbar_pkg::ST_IDLE);

  // Gated serial clock high for the second half of each data period
  assign xbar_clock = (state == xbar_pkg::ST_SHIFT) && (div_cnt >= DIV_HALF);

  // Latch pulse low for one whole period
  assign pclk = (state != xbar_pkg::ST_LATCH);

  // MSB first and held low when not shifting
  assign sin = (state == xbar_pkg::ST_SHIFT) && shreg[`XBAR_IMAGE_W-1];

endmodule

// File: src/xbar_control.sv
`timescale 1ns/1ps
`include "xbar_defs.svh"

module xbar_control #(
  parameter int POSITION = 0
) (
  input  logic                    ebi_clk,
  input  logic                    reset,
  input  logic                    re,
  input  logic                    wr,
  input  logic [`XBAR_DATA_W-1:0] data,
  input  logic [`XBAR_ADDR_W-1:0] addr,
  output logic [`XBAR_DATA_W-1:0] rdata,
  output logic                    rvalid,
  output logic                    xbar_clock,
  output logic                    pclk,
  output logic                    sin
);

  logic [`XBAR_IMAGE_W-1:0] image;
  logic                     load_start;
  logic                     busy;

  // EBI side, image store and command decode
  xbar_regs #(
    .POSITION (POSITION)
  ) u_regs (
    .ebi_clk    (ebi_clk),
    .reset      (reset),
    .re         (re),
    .wr         (wr),
    .data       (data),
    .addr       (addr),
    .busy       (busy),
    .image      (image),
    .load_start (load_start),
    .rdata      (rdata),
    .rvalid     (rvalid)
  );

  // Serial side, drives the crossbar configuration pins
  xbar_shifter u_shifter (
    .ebi_clk    (ebi_clk),
    .reset      (reset),
    .image      (image),
    .load_start (load_start),
    .busy       (busy),
    .xbar_clock (xbar_clock),
    .pclk       (pclk),
    .sin        (sin)
  );

endmodule

// File: tests/xbar_control_properties.sv
`timescale 1ns/1ps
`include "xbar_defs.svh"

module xbar_control_properties (
  input logic                  ebi_clk,
  input logic                  reset,
  input xbar_pkg::xbar_state_e state,
  input logic                  busy,
  input logic                  xbar_clock,
  input logic                  pclk,
  input logic                  sin
);

  localparam int BUSY_CYCLES = 257 * `XBAR_SCLK_DIV;
  localparam int SCLK_HALF   = `XBAR_SCLK_DIV / 2;

  int   busy_len;
  logic busy_q;
  int   fail_pclk;
  int   fail_sclk;
  int   fail_sin;
  int   fail_busy;
  int   fail_count;

  // Length of the current or last busy window
  always_ff @(posedge ebi_clk) begin
    if (reset) begin
      busy_len <= 0;
      busy_q   <= 1'b0;
    end else begin
      busy_q <= busy;
      if (busy && !busy_q) begin
        busy_len <= 1;
      end else if (busy) begin
        busy_len <= busy_len + 1;
      end
    end
  end

  assign fail_count = fail_pclk + fail_sclk + fail_sin + fail_busy;

  // Latch pulse spans one serial period and ends back in idle
  a_pclk_latch: assert property (@(posedge ebi_clk) disable iff (reset)
    $rose(pclk) |-> (state == xbar_pkg::ST_IDLE) &&
                    !$past(pclk, `XBAR_SCLK_DIV) &&
                    $past(pclk, `XBAR_SCLK_DIV + 1))
    else begin
      fail_pclk = fail_pclk + 1;
      $error("pclk low pulse was not one serial period long or did not end in idle");
    end

  // High phase of the serial clock is half a period
  a_sclk_gated: assert property (@(posedge ebi_clk) disable iff (reset)
    $fell(xbar_clock) |-> $past(xbar_clock, SCLK_HALF) && !$past(xbar_clock, SCLK_HALF + 1))
    else begin
      fail_sclk = fail_sclk + 1;
      $error("xbar_clock high time was not half a serial period");
    end

  // Chip samples sin while xbar_clock is high
  a_sin_stable: assert property (@(posedge ebi_clk) disable iff (reset)
    xbar_clock |-> $stable(sin))
    else begin
      fail_sin = fail_sin + 1;
      $error("sin changed while xbar_clock was high");
    end

  a_busy_len: assert property (@(posedge ebi_clk) disable iff (reset)
    $fell(busy) |-> (busy_len == BUSY_CYCLES))
    else begin
      fail_busy = fail_busy + 1;
      $error("busy lasted %0d cycles instead of %0d", busy_len, BUSY_CYCLES);
    end

endmodule

bind xbar_shifter xbar_control_properties u_props (
  .ebi_clk    (ebi_clk),
  .reset      (reset),
  .state      (state),
  .busy       (busy),
  .xbar_clock (xbar_clock),
  .pclk       (pclk),
  .sin        (sin)
);

// File: tests/xbar_control_tb.sv
`timescale 1ns/1ps
`include "xbar_defs.svh"

module xbar_control_tb;

  localparam logic [7:0] MY_POS     = 8'd5;
  localparam logic [7:0] OTHER_POS  = 8'd6;
  localparam int         BITS       = `XBAR_IMAGE_W;
  localparam int         QUIET_WAIT = 200;
  localparam int         XFER_LIMIT = (BITS + 4) * `XBAR_SCLK_DIV + 100;

  logic                    ebi_clk;
  logic                    reset;
  logic                    re;
  logic                    wr;
  logic [`XBAR_DATA_W-1:0] data;
  logic [`XBAR_ADDR_W-1:0] addr;
  logic [`XBAR_DATA_W-1:0] rdata;
  logic                    rvalid;
  logic                    xbar_clock;
  logic                    pclk;
  logic                    sin;

  logic [`XBAR_DATA_W-1:0] model [`XBAR_WORDS];
  logic                    cap_q [$];
  int                      sclk_edges = 0;
  int                      pclk_falls = 0;
  logic                    sclk_prev = 1'b0;
  logic                    pclk_prev = 1'b1;
  int                      errors = 0;

  xbar_control #(
    .POSITION (5)
  ) i_dut (
    .ebi_clk    (ebi_clk),
    .reset      (reset),
    .re         (re),
    .wr         (wr),
    .data       (data),
    .addr       (addr),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .xbar_clock (xbar_clock),
    .pclk       (pclk),
    .sin        (sin)
  );

  initial begin
    ebi_clk = 1'b0;
    forever #4 ebi_clk = ~ebi_clk;
  end

  // Serial capture, sampled on the falling edge where the pins are settled
  always @(negedge ebi_clk) begin
    if (xbar_clock === 1'b1 && sclk_prev === 1'b0) begin
      cap_q.push_back(sin);
      sclk_edges = sclk_edges + 1;
    end
    if (pclk === 1'b0 && pclk_prev === 1'b1) begin
      pclk_falls = pclk_falls + 1;
    end
    sclk_prev = xbar_clock;
    pclk_prev = pclk;
  end

  // addr[13] selects the command register, addr[11:8] the image word
  function automatic logic [`XBAR_ADDR_W-1:0] make_addr(logic is_cmd, logic [3:0] idx,
                                                        logic [7:0] pos);
    return {7'd0, is_cmd, 1'b0, idx, pos};
  endfunction

  // Word 15 is the top of the image
  function automatic logic [BITS-1:0] model_image();
    logic [BITS-1:0] img;
    for (int k = 0; k < `XBAR_WORDS; k++) begin
      img[k*`XBAR_DATA_W +: `XBAR_DATA_W] = model[k];
    end
    return img;
  endfunction

  task automatic check_word(string name, logic [15:0] exp, logic [15:0] act);
    assert (act === exp) else begin
      errors++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_int(string name, int exp, int act);
    assert (act == exp) else begin
      errors++;
      $display("error %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_image(string name, logic [BITS-1:0] exp, logic [BITS-1:0] act);
    assert (act === exp) else begin
      errors++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic ebi_write(logic [`XBAR_ADDR_W-1:0] a, logic [`XBAR_DATA_W-1:0] d);
    @(posedge ebi_clk);
    addr <= a;
    data <= d;
    wr   <= 1'b1;
    @(posedge ebi_clk);
    wr <= 1'b0;
  endtask

  // Read data is due exactly one cycle after the strobe
  task automatic ebi_read(input logic [`XBAR_ADDR_W-1:0] a, output logic [15:0] d);
    @(posedge ebi_clk);
    addr <= a;
    re   <= 1'b1;
    @(posedge ebi_clk);
    re <= 1'b0;
    @(negedge ebi_clk);
    assert (rvalid === 1'b1) else begin
      errors++;
      $display("rvalid did not rise one cycle after the read strobe");
    end
    d = rdata;
  endtask

  task automatic wait_edges(int target);
    int n;
    n = 0;
    while (sclk_edges < target && n < XFER_LIMIT) begin
      @(negedge ebi_clk);
      n++;
    end
    if (sclk_edges < target) begin
      errors++;
      $display("timeout while waiting for serial clock edge %0d", target);
    end
  endtask

  task automatic check_transfer(string name, int base, int falls0, logic [BITS-1:0] exp);
    logic [BITS-1:0] got;
    int              n;
    got = '0;
    n   = 0;
    while (!(pclk_falls > falls0 && pclk === 1'b1) && n < XFER_LIMIT) begin
      @(negedge ebi_clk);
      n++;
    end
    if (!(pclk_falls > falls0 && pclk === 1'b1)) begin
      errors++;
      $display("timeout while waiting for the latch pulse of %s", name);
    end
    check_int({name, " bit count"}, BITS, sclk_edges - base);
    check_int({name, " latch pulses"}, falls0 + 1, pclk_falls);
    for (int i = 0; i < BITS; i++) begin
      if (base + i < cap_q.size()) begin
        got = {got[BITS-2:0], cap_q[base+i]};
      end
    end
    check_image({name, " bits"}, exp, got);
  endtask

  initial begin
    logic [15:0]     rd;
    logic [BITS-1:0] first_img;
    int              base;
    int              falls0;
    int              prop_fails;
    void'($urandom(27));
    reset = 1'b1;
    re    = 1'b0;
    wr    = 1'b0;
    data  = '0;
    addr  = '0;
    repeat (16) @(posedge ebi_clk);
    reset <= 1'b0;
    @(negedge ebi_clk);

    // Pin levels out of reset
    check_word("reset pclk", 16'd1, {15'd0, pclk});
    check_word("reset xbar_clock", 16'd0, {15'd0, xbar_clock});
    check_word("reset sin", 16'd0, {15'd0, sin});
    check_word("reset rvalid", 16'd0, {15'd0, rvalid});

    for (int k = 0; k < `XBAR_WORDS; k++) begin
      model[k] = 16'($urandom());
      ebi_write(make_addr(1'b0, 4'(k), MY_POS), model[k]);
    end
    for (int k = 0; k < `XBAR_WORDS; k++) begin
      ebi_read(make_addr(1'b0, 4'(k), MY_POS), rd);
      check_word("image readback", model[k], rd);
    end
    ebi_read(make_addr(1'b1, 4'd0, MY_POS), rd);
    check_word("idle status", 16'd0, rd);

    first_img = model_image();
    base      = sclk_edges;
    falls0    = pclk_falls;
    ebi_write(make_addr(1'b1, 4'd0, MY_POS), xbar_pkg::CMD_LOAD);
    check_transfer("first load", base, falls0, first_img);

    // Another crossbar's slot must leave this one untouched
    base = sclk_edges;
    for (int k = 0; k < `XBAR_WORDS; k++) begin
      ebi_write(make_addr(1'b0, 4'(k), OTHER_POS), 16'($urandom()));
    end
    ebi_write(make_addr(1'b1, 4'd0, OTHER_POS), xbar_pkg::CMD_LOAD);
    repeat (QUIET_WAIT) @(negedge ebi_clk);
    check_int("foreign position edges", 0, sclk_edges - base);
    for (int k = 0; k < `XBAR_WORDS; k++) begin
      ebi_read(make_addr(1'b0, 4'(k), MY_POS), rd);
      check_word("foreign position readback", model[k], rd);
    end

    // New image and a second LOAD while the first transfer runs
    base   = sclk_edges;
    falls0 = pclk_falls;
    ebi_write(make_addr(1'b1, 4'd0, MY_POS), xbar_pkg::CMD_LOAD);
    wait_edges(base + 64);
    for (int k = 0; k < `XBAR_WORDS; k++) begin
      model[k] = 16'($urandom());
      ebi_write(make_addr(1'b0, 4'(k), MY_POS), model[k]);
    end
    ebi_write(make_addr(1'b1, 4'd0, MY_POS), xbar_pkg::CMD_LOAD);
    ebi_read(make_addr(1'b1, 4'd0, MY_POS), rd);
    check_word("busy status", 16'd1, rd);
    check_transfer("load while busy", base, falls0, first_img);
    repeat (QUIET_WAIT) @(negedge ebi_clk);
    check_int("no restart edges", BITS, sclk_edges - base);

    base   = sclk_edges;
    falls0 = pclk_falls;
    ebi_write(make_addr(1'b1, 4'd0, MY_POS), xbar_pkg::CMD_LOAD);
    check_transfer("reload", base, falls0, model_image());

    prop_fails = i_dut.u_shifter.u_props.fail_count;
    $display("check errors: %0d, assertion failures: %0d", errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+src
src/xbar_pkg.sv
src/xbar_regs.sv
src/xbar_shifter.sv
src/xbar_control.sv
tests/xbar_control_properties.sv
tests/xbar_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the crossbar control testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f filelist.f --top-module xbar_control_tb \
  -o xbar_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/xbar_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
